// ==== design/gpio_pkg.sv ====
package gpio_pkg;

   // ------------------------------------------------------------
   // sizes and register map
   // ------------------------------------------------------------
   localparam int NUM_PINS = 32;
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 8;

   localparam logic [ADDR_W-1:0] ADDR_IRQ   = 8'h80;
   localparam logic [ADDR_W-1:0] ADDR_GPIN  = 8'h90;
   localparam logic [ADDR_W-1:0] ADDR_GPOUT = 8'hA0;
   // pin n config lives at 4*n
   localparam logic [ADDR_W-1:0] CFG_LAST   = 8'h7C;

   localparam logic [NUM_PINS-1:0] GPOUT_RESET = '0;

   // ------------------------------------------------------------
   // types
   // ------------------------------------------------------------
   typedef logic [NUM_PINS-1:0] pins_t;

   // 5 and 6 are unused, treated as off
   typedef enum logic [2:0] {
      INT_LVL_HIGH  = 3'd0,
      INT_LVL_LOW   = 3'd1,
      INT_EDGE_POS  = 3'd2,
      INT_EDGE_NEG  = 3'd3,
      INT_EDGE_BOTH = 3'd4,
      INT_OFF       = 3'd7
   } int_type_e;

   typedef struct packed {
      int_type_e int_type;
      logic      spare;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   typedef struct packed {
      logic              sel;
      logic              enable;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } apb_req_t;

   // config byte sits in the low bits of the write word
   typedef struct packed {
      logic [DATA_W-9:0] pad;
      pin_cfg_t          cfg;
   } cfg_word_t;

   // same write word seen as pin bits or as a config byte
   typedef union packed {
      pins_t     pins;
      cfg_word_t cfg_word;
   } wdata_u;

endpackage

// ==== design/gpio_in_sync.sv ====
`timescale 1ns/1ps

module gpio_in_sync
(
   input  logic            PCLK,
   input  logic            PRESETN,
   input  gpio_pkg::pins_t gpio_in_i,
   output gpio_pkg::pins_t sync_lvl_o,
   output gpio_pkg::pins_t rise_o,
   output gpio_pkg::pins_t fall_o
);

   gpio_pkg::pins_t stage1_q;
   gpio_pkg::pins_t stage2_q;
   gpio_pkg::pins_t stage3_q;

   // ------------------------------------------------------------
   // three flop chain per pin
   // ------------------------------------------------------------
   always_ff @(posedge PCLK or negedge PRESETN)
   begin
      if (!PRESETN)
      begin
         stage1_q <= '0;
         stage2_q <= '0;
         stage3_q <= '0;
      end
      else
      begin
         stage1_q <= gpio_in_i;
         stage2_q <= stage1_q;
         stage3_q <= stage2_q;
      end
   end

   assign sync_lvl_o = stage3_q;

   // transition is visible one cycle before it reaches the last stage
   assign rise_o = stage2_q & ~stage3_q;
   assign fall_o = ~stage2_q & stage3_q;

endmodule

// ==== design/gpio_irq_detect.sv ====
`timescale 1ns/1ps

module gpio_irq_detect
(
   input  logic                                     PCLK,
   input  logic                                     PRESETN,
   input  gpio_pkg::pin_cfg_t [gpio_pkg::NUM_PINS-1:0] cfg_i,
   input  gpio_pkg::pins_t                          sync_lvl_i,
   input  gpio_pkg::pins_t                          rise_i,
   input  gpio_pkg::pins_t                          fall_i,
   input  gpio_pkg::pins_t                          irq_clr_i,
   output gpio_pkg::pins_t                          int_o,
   output logic                                     int_or_o,
   output gpio_pkg::pins_t                          irq_reg_o
);

   gpio_pkg::pins_t edge_pos_q;
   gpio_pkg::pins_t edge_neg_q;
   gpio_pkg::pins_t edge_both_q;
   gpio_pkg::pins_t use_pos;
   gpio_pkg::pins_t use_neg;
   gpio_pkg::pins_t use_both;
   gpio_pkg::pins_t int_en;
   gpio_pkg::pins_t int_sel;
   gpio_pkg::pins_t irq_q;

   // set wins over clear, flag forced low when not in use
   function automatic gpio_pkg::pins_t next_flag(
      input gpio_pkg::pins_t use_v,
      input gpio_pkg::pins_t set_v,
      input gpio_pkg::pins_t flag_v,
      input gpio_pkg::pins_t clr_v
   );
      return use_v & (set_v | (flag_v & ~clr_v));
   endfunction

   // ------------------------------------------------------------
   // per pin type decode
   // ------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::NUM_PINS; i++)
      begin
         int_en[i]   = cfg_i[i].int_en;
         use_pos[i]  = cfg_i[i].int_en && (cfg_i[i].int_type == gpio_pkg::INT_EDGE_POS);
         use_neg[i]  = cfg_i[i].int_en && (cfg_i[i].int_type == gpio_pkg::INT_EDGE_NEG);
         use_both[i] = cfg_i[i].int_en && (cfg_i[i].int_type == gpio_pkg::INT_EDGE_BOTH);
         case (cfg_i[i].int_type)
            gpio_pkg::INT_LVL_HIGH:  int_sel[i] = sync_lvl_i[i];
            gpio_pkg::INT_LVL_LOW:   int_sel[i] = ~sync_lvl_i[i];
            gpio_pkg::INT_EDGE_POS:  int_sel[i] = edge_pos_q[i];
            gpio_pkg::INT_EDGE_NEG:  int_sel[i] = edge_neg_q[i];
            gpio_pkg::INT_EDGE_BOTH: int_sel[i] = edge_both_q[i];
            default:                 int_sel[i] = 1'b0;
         endcase
      end
   end

   // ------------------------------------------------------------
   // sticky edge flags
   // ------------------------------------------------------------
   always_ff @(posedge PCLK or negedge PRESETN)
   begin
      if (!PRESETN)
      begin
         edge_pos_q  <= '0;
         edge_neg_q  <= '0;
         edge_both_q <= '0;
      end
      else
      begin
         edge_pos_q  <= next_flag(use_pos, rise_i, edge_pos_q, irq_clr_i);
         edge_neg_q  <= next_flag(use_neg, fall_i, edge_neg_q, irq_clr_i);
         edge_both_q <= next_flag(use_both, rise_i | fall_i, edge_both_q, irq_clr_i);
      end
   end

   assign int_o    = int_sel & int_en;
   assign int_or_o = |int_o;

   // interrupt register, write one to clear
   always_ff @(posedge PCLK or negedge PRESETN)
   begin
      if (!PRESETN)
         irq_q <= '0;
      else if (|irq_clr_i)
         irq_q <= irq_q & ~irq_clr_i;
      else
         irq_q <= int_o;
   end

   assign irq_reg_o = irq_q;

endmodule

// ==== design/gpio_apb_regs.sv ====
`timescale 1ns/1ps

module gpio_apb_regs
(
   input  logic                                     PCLK,
   input  logic                                     PRESETN,
   input  gpio_pkg::apb_req_t                       apb_i,
   input  gpio_pkg::pins_t                          sync_lvl_i,
   input  gpio_pkg::pins_t                          irq_reg_i,
   output gpio_pkg::pin_cfg_t [gpio_pkg::NUM_PINS-1:0] cfg_o,
   output gpio_pkg::pins_t                          irq_clr_o,
   output logic [gpio_pkg::DATA_W-1:0]              prdata_o,
   output logic                                     pready_o,
   output logic                                     pslverr_o,
   output gpio_pkg::pins_t                          gpio_out_o,
   output gpio_pkg::pins_t                          gpio_oe_o
);

   gpio_pkg::pin_cfg_t [gpio_pkg::NUM_PINS-1:0] cfg_q;
   gpio_pkg::pins_t                            gpout_q;
   gpio_pkg::wdata_u                           wd;
   logic [$clog2(gpio_pkg::NUM_PINS)-1:0]      pin_idx;
   logic                                       wr_en;
   logic                                       cfg_hit;
   gpio_pkg::pins_t                            out_en;
   gpio_pkg::pins_t                            oe_en;
   gpio_pkg::pins_t                            in_en;

   // ------------------------------------------------------------
   // APB decode
   // ------------------------------------------------------------
   assign wd      = apb_i.wdata;
   assign wr_en   = apb_i.sel && apb_i.enable && apb_i.write;
   assign cfg_hit = (apb_i.addr <= gpio_pkg::CFG_LAST);
   assign pin_idx = apb_i.addr[2 +: $clog2(gpio_pkg::NUM_PINS)];

   // no wait states, never an error
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   always_ff @(posedge PCLK or negedge PRESETN)
   begin
      if (!PRESETN)
         cfg_q <= '0;
      else if (wr_en && cfg_hit)
         cfg_q[pin_idx] <= wd.cfg_word.cfg;
   end

   always_ff @(posedge PCLK or negedge PRESETN)
   begin
      if (!PRESETN)
         gpout_q <= gpio_pkg::GPOUT_RESET;
      else if (wr_en && (apb_i.addr == gpio_pkg::ADDR_GPOUT))
         gpout_q <= wd.pins;
   end

   // clear mask only lives in the write cycle
   assign irq_clr_o = (wr_en && (apb_i.addr == gpio_pkg::ADDR_IRQ)) ? wd.pins : '0;

   assign cfg_o = cfg_q;

   // ------------------------------------------------------------
   // per pin enables and pin outputs
   // ------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::NUM_PINS; i++)
      begin
         out_en[i] = cfg_q[i].out_en;
         oe_en[i]  = cfg_q[i].oe_en;
         in_en[i]  = cfg_q[i].in_en;
      end
   end

   assign gpio_out_o = gpout_q & out_en;
   assign gpio_oe_o  = oe_en & out_en;

   // read data straight from the current address
   always_comb
   begin
      prdata_o = '0;
      if (cfg_hit)
         prdata_o = {{(gpio_pkg::DATA_W-8){1'b0}}, cfg_q[pin_idx]};
      else
      begin
         case (apb_i.addr)
            gpio_pkg::ADDR_IRQ:   prdata_o = irq_reg_i;
            gpio_pkg::ADDR_GPIN:  prdata_o = sync_lvl_i & in_en;
            gpio_pkg::ADDR_GPOUT: prdata_o = gpout_q;
            default:              prdata_o = '0;
         endcase
      end
   end

endmodule

// ==== design/gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top
(
   input  logic                          PCLK,
   input  logic                          PRESETN,
   input  logic                          psel_i,
   input  logic                          penable_i,
   input  logic                          pwrite_i,
   input  logic [gpio_pkg::ADDR_W-1:0]   paddr_i,
   input  logic [gpio_pkg::DATA_W-1:0]   pwdata_i,
   input  gpio_pkg::pins_t               gpio_in_i,
   output logic [gpio_pkg::DATA_W-1:0]   prdata_o,
   output logic                          pready_o,
   output logic                          pslverr_o,
   output gpio_pkg::pins_t               gpio_out_o,
   output gpio_pkg::pins_t               gpio_oe_o,
   output gpio_pkg::pins_t               int_o,
   output logic                          int_or_o
);

   gpio_pkg::apb_req_t                          apb_req;
   gpio_pkg::pins_t                             sync_lvl;
   gpio_pkg::pins_t                             rise;
   gpio_pkg::pins_t                             fall;
   gpio_pkg::pins_t                             irq_clr;
   gpio_pkg::pins_t                             irq_reg;
   gpio_pkg::pin_cfg_t [gpio_pkg::NUM_PINS-1:0] cfg;

   assign apb_req = {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i};

   gpio_in_sync i_gpio_in_sync
   (
      .PCLK       (PCLK),
      .PRESETN    (PRESETN),
      .gpio_in_i  (gpio_in_i),
      .sync_lvl_o (sync_lvl),
      .rise_o     (rise),
      .fall_o     (fall)
   );

   gpio_irq_detect i_gpio_irq_detect
   (
      .PCLK       (PCLK),
      .PRESETN    (PRESETN),
      .cfg_i      (cfg),
      .sync_lvl_i (sync_lvl),
      .rise_i     (rise),
      .fall_i     (fall),
      .irq_clr_i  (irq_clr),
      .int_o      (int_o),
      .int_or_o   (int_or_o),
      .irq_reg_o  (irq_reg)
   );

   gpio_apb_regs i_gpio_apb_regs
   (
      .PCLK       (PCLK),
      .PRESETN    (PRESETN),
      .apb_i      (apb_req),
      .sync_lvl_i (sync_lvl),
      .irq_reg_i  (irq_reg),
      .cfg_o      (cfg),
      .irq_clr_o  (irq_clr),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

endmodule

// ==== dv/gpio_tb_util.svh ====
`ifndef GPIO_TB_UTIL_SVH
`define GPIO_TB_UTIL_SVH

typedef gpio_pkg::pin_cfg_t [gpio_pkg::NUM_PINS-1:0] cfg_arr_t;

typedef struct packed {
   logic [gpio_pkg::DATA_W-1:0] rdata;
   gpio_pkg::pins_t             out;
   gpio_pkg::pins_t             oe;
   gpio_pkg::pins_t             irq;
} expect_t;

// galois lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int k = 0; k < n; k++)
   begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
   end
   return v;
endfunction

// ------------------------------------------------------------
// expected read data and pin outputs
// ------------------------------------------------------------
function automatic expect_t ref_model(input cfg_arr_t cfg, input gpio_pkg::pins_t gpout,
                                      input gpio_pkg::pins_t lvl, input gpio_pkg::pins_t flags,
                                      input logic [7:0] addr);
   expect_t e;
   e = '0;
   for (int i = 0; i < gpio_pkg::NUM_PINS; i++)
   begin
      e.out[i] = gpout[i] & cfg[i].out_en;
      e.oe[i]  = cfg[i].oe_en & cfg[i].out_en;
      if (cfg[i].int_en)
      begin
         case (cfg[i].int_type)
            gpio_pkg::INT_LVL_HIGH:  e.irq[i] = lvl[i];
            gpio_pkg::INT_LVL_LOW:   e.irq[i] = ~lvl[i];
            gpio_pkg::INT_EDGE_POS,
            gpio_pkg::INT_EDGE_NEG,
            gpio_pkg::INT_EDGE_BOTH: e.irq[i] = flags[i];
            default:                 e.irq[i] = 1'b0;
         endcase
      end
   end
   if (addr <= gpio_pkg::CFG_LAST)
      e.rdata = {24'h0, cfg[addr[6:2]]};
   else if (addr == gpio_pkg::ADDR_IRQ)
      e.rdata = e.irq;
   else if (addr == gpio_pkg::ADDR_GPIN)
      for (int i = 0; i < gpio_pkg::NUM_PINS; i++)
         e.rdata[i] = lvl[i] & cfg[i].in_en;
   else if (addr == gpio_pkg::ADDR_GPOUT)
      e.rdata = gpout;
   return e;
endfunction

// sticky flags set by a pin change per type and direction
function automatic gpio_pkg::pins_t edge_update(input cfg_arr_t cfg,
                                                input gpio_pkg::pins_t old_v,
                                                input gpio_pkg::pins_t new_v,
                                                input gpio_pkg::pins_t flags);
   gpio_pkg::pins_t f;
   f = flags;
   for (int i = 0; i < gpio_pkg::NUM_PINS; i++)
   begin
      if (cfg[i].int_en && (old_v[i] != new_v[i]))
      begin
         case (cfg[i].int_type)
            gpio_pkg::INT_EDGE_POS:  f[i] = f[i] | new_v[i];
            gpio_pkg::INT_EDGE_NEG:  f[i] = f[i] | old_v[i];
            gpio_pkg::INT_EDGE_BOTH: f[i] = 1'b1;
            default:                 f[i] = f[i];
         endcase
      end
   end
   return f;
endfunction

task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
   $display("ERR %0t %s expected %h actual %h", $time, sig, exp_v, act_v);
   $display("TEST FAILED");
   $fatal(1, "mismatch on %s", sig);
endtask

// ------------------------------------------------------------
// APB accesses
// ------------------------------------------------------------
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
   @(posedge PCLK);
   psel_i   <= 1'b1;
   pwrite_i <= 1'b1;
   paddr_i  <= addr;
   pwdata_i <= data;
   @(posedge PCLK);
   penable_i <= 1'b1;
   do
      @(posedge PCLK);
   while (!pready_o);
   psel_i    <= 1'b0;
   penable_i <= 1'b0;
   pwrite_i  <= 1'b0;
endtask

// compare process checks during the enable phase
task automatic apb_read(input logic [7:0] addr);
   @(posedge PCLK);
   psel_i   <= 1'b1;
   pwrite_i <= 1'b0;
   paddr_i  <= addr;
   @(posedge PCLK);
   penable_i <= 1'b1;
   cmp_req   <= 1'b1;
   do
      @(posedge PCLK);
   while (!pready_o);
   psel_i    <= 1'b0;
   penable_i <= 1'b0;
   cmp_req   <= 1'b0;
endtask

`endif

// ==== dv/gpio_tb.sv ====
`timescale 1ns/1ps

module gpio_tb;

   localparam int CLK_HALF = 4;
   // APB accesses in the whole sequence
   localparam int N_TXN    = 195;
   localparam int WDOG_CYC = N_TXN * 10 + 200;

   logic                        PCLK;
   logic                        PRESETN;
   logic                        psel_i;
   logic                        penable_i;
   logic                        pwrite_i;
   logic [gpio_pkg::ADDR_W-1:0] paddr_i;
   logic [gpio_pkg::DATA_W-1:0] pwdata_i;
   gpio_pkg::pins_t             gpio_in_i;
   logic [gpio_pkg::DATA_W-1:0] prdata_o;
   logic                        pready_o;
   logic                        pslverr_o;
   gpio_pkg::pins_t             gpio_out_o;
   gpio_pkg::pins_t             gpio_oe_o;
   gpio_pkg::pins_t             int_o;
   logic                        int_or_o;

   logic [15:0]     lfsr_q;
   logic            cmp_req;
   logic            irq_chk;
   gpio_pkg::pins_t gpout_m;
   gpio_pkg::pins_t in_m;
   gpio_pkg::pins_t edge_m;

`include "gpio_tb_util.svh"

   cfg_arr_t cfg_m;
   expect_t  exp_v;

   gpio_top i_gpio_top
   (
      .PCLK       (PCLK),
      .PRESETN    (PRESETN),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .gpio_in_i  (gpio_in_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o),
      .int_o      (int_o),
      .int_or_o   (int_or_o)
   );

   always #CLK_HALF PCLK = ~PCLK;

   // random enables with a type from the level set or the edge set
   function automatic gpio_pkg::pin_cfg_t rand_irq_cfg(input logic edge_mode);
      logic [31:0]        r;
      gpio_pkg::pin_cfg_t c;
      r = rand_bits(6);
      c = {4'h0, r[3:0]};
      if (edge_mode)
         c.int_type = gpio_pkg::int_type_e'((r[5:4] == 2'd3) ? 3'd4 : {1'b0, r[5:4]} + 3'd2);
      else
         c.int_type = gpio_pkg::int_type_e'({r[5], r[5] & r[4], r[5] | r[4]});
      return c;
   endfunction

   task automatic write_cfg(input int pin, input gpio_pkg::pin_cfg_t c);
      apb_write(8'(pin * 4), {24'h0, c});
      cfg_m[pin] = c;
   endtask

   // drive new pin levels and let the synchronizer settle
   task automatic drive_pins(input gpio_pkg::pins_t v);
      @(posedge PCLK);
      gpio_in_i <= v;
      edge_m = edge_update(cfg_m, in_m, v, edge_m);
      in_m   = v;
      repeat (4) @(posedge PCLK);
   endtask

   // ------------------------------------------------------------
   // compare process
   // ------------------------------------------------------------
   always @(negedge PCLK)
   begin
      if (cmp_req)
      begin
         exp_v = ref_model(cfg_m, gpout_m, in_m, edge_m, paddr_i);
         assert (prdata_o === exp_v.rdata)
         else report_mismatch("prdata_o", exp_v.rdata, prdata_o);
         assert (gpio_out_o === exp_v.out)
         else report_mismatch("gpio_out_o", exp_v.out, gpio_out_o);
         assert (gpio_oe_o === exp_v.oe)
         else report_mismatch("gpio_oe_o", exp_v.oe, gpio_oe_o);
         assert (pready_o === 1'b1)
         else report_mismatch("pready_o", 32'd1, pready_o);
         assert (pslverr_o === 1'b0)
         else report_mismatch("pslverr_o", 32'd0, pslverr_o);
         if (irq_chk)
         begin
            assert (int_o === exp_v.irq)
            else report_mismatch("int_o", exp_v.irq, int_o);
            assert (int_or_o === (|exp_v.irq))
            else report_mismatch("int_or_o", |exp_v.irq, int_or_o);
         end
      end
   end

   initial
   begin
      #(WDOG_CYC * 2 * CLK_HALF);
      $display("timeout: the test sequence did not finish in time");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin : main_seq
      logic [31:0] v;
      logic [4:0]  pin;
      PCLK      = 1'b0;
      PRESETN   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      gpio_in_i = '0;
      lfsr_q    = 16'd97;
      cmp_req   = 1'b0;
      irq_chk   = 1'b1;
      cfg_m     = '0;
      gpout_m   = '0;
      in_m      = '0;
      edge_m    = '0;
      repeat (2) @(posedge PCLK);
      PRESETN <= 1'b1;

      // reset values
      for (int p = 0; p < gpio_pkg::NUM_PINS; p++)
         apb_read(8'(p * 4));
      apb_read(gpio_pkg::ADDR_IRQ);
      apb_read(gpio_pkg::ADDR_GPIN);
      apb_read(gpio_pkg::ADDR_GPOUT);

      // config read back and unmapped holes
      irq_chk = 1'b0;
      repeat (16)
      begin
         pin = 5'(rand_bits(5));
         v   = rand_bits(8);
         write_cfg(pin, v[7:0]);
         apb_read({1'b0, pin, 2'b00});
      end
      apb_read(8'h84);
      apb_read(8'hB0);

      // output path
      for (int p = 0; p < gpio_pkg::NUM_PINS; p++)
      begin
         v = rand_bits(8);
         write_cfg(p, v[7:0]);
      end
      v = rand_bits(32);
      apb_write(gpio_pkg::ADDR_GPOUT, v);
      gpout_m = v;
      apb_read(gpio_pkg::ADDR_GPOUT);

      // input path
      repeat (4)
      begin
         drive_pins(rand_bits(32));
         apb_read(gpio_pkg::ADDR_GPIN);
      end

      // level interrupts
      for (int p = 0; p < gpio_pkg::NUM_PINS; p++)
         write_cfg(p, rand_irq_cfg(1'b0));
      irq_chk = 1'b1;
      repeat (4)
      begin
         drive_pins(rand_bits(32));
         apb_read(gpio_pkg::ADDR_IRQ);
         apb_read(gpio_pkg::ADDR_GPIN);
      end

      // edge interrupts stay sticky until write one to clear
      for (int p = 0; p < gpio_pkg::NUM_PINS; p++)
         write_cfg(p, rand_irq_cfg(1'b1));
      edge_m = '0;
      repeat (4)
      begin
         drive_pins(rand_bits(32));
         apb_read(gpio_pkg::ADDR_IRQ);
         drive_pins(rand_bits(32));
         apb_read(gpio_pkg::ADDR_IRQ);
         v = rand_bits(32);
         apb_write(gpio_pkg::ADDR_IRQ, v);
         edge_m = edge_m & ~v;
         apb_read(gpio_pkg::ADDR_IRQ);
      end

      $display("TEST OK");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+dv
design/gpio_pkg.sv
design/gpio_in_sync.sv
design/gpio_irq_detect.sv
design/gpio_apb_regs.sv
design/gpio_top.sv
dv/gpio_tb.sv
